// File: hdl/serial_bus_pkg.sv
package serial_bus_pkg;

    // bus widths
    localparam int DATA_WIDTH  = 32;
    localparam int ADDR_WIDTH  = 11;
    localparam int S_ID_WIDTH  = 2;
    localparam int START_WIDTH = 3;

    // start field of every header, all ones
    localparam logic [START_WIDTH-1:0] START_CODE = '1;

    // start + id + write + burst + address
    localparam int HDR_LEN = START_WIDTH + S_ID_WIDTH + 1 + 1 + ADDR_WIDTH;

    // largest value the bit counter must reach
    localparam int CNT_MAX       = (HDR_LEN > DATA_WIDTH) ? HDR_LEN : DATA_WIDTH;
    localparam int CNT_WIDTH     = $clog2(CNT_MAX + 1);

    typedef logic [DATA_WIDTH-1:0] data_word_t;
    typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [S_ID_WIDTH-1:0] slave_id_t;
    typedef logic [CNT_WIDTH-1:0]  bit_count_t;

    // fields in transmission order, first bit on the wire is start MSB
    typedef struct packed {
        logic [START_WIDTH-1:0] start;
        slave_id_t              id;
        logic                   write;
        logic                   burst;
        mem_addr_t              addr;
    } frame_hdr_t;

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        DECODE,
        RD_FETCH,
        RD_SHIFT,
        WR_SHIFT,
        WR_COMMIT
    } slave_state_t;

endpackage

// File: hdl/slave_bit_counter.sv
`timescale 1ns/100ps

module slave_bit_counter (
    input  logic clk,
    input  logic rstN,
    input  logic cnt_clear,
    input  logic cnt_step,
    input  logic cnt_mode,
    output logic count_done
);

    serial_bus_pkg::bit_count_t count;
    serial_bus_pkg::bit_count_t limit;

    // mode 0 counts header bits, mode 1 data bits
    assign limit = cnt_mode ? serial_bus_pkg::bit_count_t'(serial_bus_pkg::DATA_WIDTH)
                            : serial_bus_pkg::bit_count_t'(serial_bus_pkg::HDR_LEN);

    // high on the step that brings the count to the limit
    assign count_done = cnt_step && (count == limit - 1'b1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (cnt_clear) begin
            count <= '0;
        end else if (cnt_step) begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: hdl/header_deserializer.sv
`timescale 1ns/100ps

module header_deserializer #(
    parameter serial_bus_pkg::slave_id_t SLAVE_ID = 1
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       control,
    input  logic                       hdr_shift,
    output serial_bus_pkg::frame_hdr_t hdr,
    output logic                       hdr_match
);

    logic [serial_bus_pkg::HDR_LEN-1:0] hdr_bits;

    // msb first, so new bits enter at bit 0
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hdr_bits <= '0;
        end else if (hdr_shift) begin
            hdr_bits <= {hdr_bits[serial_bus_pkg::HDR_LEN-2:0], control};
        end
    end

    assign hdr = serial_bus_pkg::frame_hdr_t'(hdr_bits);

    // frame is ours only with a clean start code and our id
    assign hdr_match = (hdr.start == serial_bus_pkg::START_CODE) && (hdr.id == SLAVE_ID);

endmodule

// File: hdl/data_shifter.sv
`timescale 1ns/100ps

module data_shifter (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       wD,
    input  logic                       wr_shift,
    input  logic                       rd_load,
    input  logic                       rd_shift,
    input  serial_bus_pkg::data_word_t rd_word,
    output serial_bus_pkg::data_word_t wr_word,
    output logic                       rD
);

    localparam int W = serial_bus_pkg::DATA_WIDTH;

    // bits still waiting behind the one on rD
    serial_bus_pkg::data_word_t rd_reg;
    logic                       rd_bit;

    // write side, first bit received ends up as the MSB
    always_ff @(posedge clk) begin
        if (wr_shift) begin
            wr_word <= {wr_word[W-2:0], wD};
        end
    end

    // read side
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd_reg <= '0;
            rd_bit <= 1'b0;
        end else if (rd_load) begin
            rd_bit <= rd_word[W-1];
            rd_reg <= {rd_word[W-2:0], 1'b0};
        end else if (rd_shift) begin
            rd_bit <= rd_reg[W-1];
            rd_reg <= {rd_reg[W-2:0], 1'b0};
        end
    end

    assign rD = rd_bit;

endmodule

// File: hdl/slave_memory.sv
`timescale 1ns/100ps

module slave_memory #(
    parameter int ADDR_DEPTH = 2000
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       addr_load,
    input  serial_bus_pkg::mem_addr_t  hdr_addr,
    input  logic                       addr_step,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  serial_bus_pkg::data_word_t wr_word,
    output serial_bus_pkg::data_word_t rd_word
);

    serial_bus_pkg::data_word_t ram [ADDR_DEPTH];
    serial_bus_pkg::mem_addr_t  addr_q;
    serial_bus_pkg::mem_addr_t  addr_d;

    always_comb begin
        addr_d = addr_q;
        if (addr_load) begin
            addr_d = hdr_addr;
        end else if (addr_step) begin
            addr_d = addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addr_q <= '0;
        end else begin
            addr_q <= addr_d;
        end
    end

    // reads see the address being loaded, writes the current one
    always_ff @(posedge clk) begin
        if (mem_write) begin
            ram[addr_q] <= wr_word;
        end
        if (mem_read) begin
            rd_word <= ram[addr_d];
        end
    end

endmodule

// File: hdl/slave_frame_fsm.sv
`timescale 1ns/100ps

module slave_frame_fsm (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      control,
    input  logic                      valid,
    input  logic                      last,
    input  logic                      count_done,
    input  logic                      hdr_match,
    input  serial_bus_pkg::frame_hdr_t hdr,
    output logic                      ready,
    output logic                      hdr_shift,
    output logic                      cnt_clear,
    output logic                      cnt_step,
    output logic                      cnt_mode,
    output logic                      addr_load,
    output logic                      addr_step,
    output logic                      mem_read,
    output logic                      mem_write,
    output logic                      rd_load,
    output logic                      rd_shift,
    output logic                      wr_shift
);

    serial_bus_pkg::slave_state_t state_q;
    serial_bus_pkg::slave_state_t state_d;

    // last seen somewhere in the current burst word
    logic last_seen;
    logic rd_final;
    logic wr_final;

    // a read word also ends on last in its own final bit cycle
    assign rd_final = !hdr.burst || last_seen || last;
    assign wr_final = !hdr.burst || last_seen;

    // high while the master may move bits
    assign ready = (state_q == serial_bus_pkg::IDLE)     ||
                   (state_q == serial_bus_pkg::HEADER)   ||
                   (state_q == serial_bus_pkg::RD_SHIFT) ||
                   (state_q == serial_bus_pkg::WR_SHIFT);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state_q <= serial_bus_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            last_seen <= 1'b0;
        end else if (state_q == serial_bus_pkg::DECODE   ||
                     state_q == serial_bus_pkg::RD_FETCH ||
                     state_q == serial_bus_pkg::WR_COMMIT) begin
            last_seen <= 1'b0;
        end else if ((state_q == serial_bus_pkg::RD_SHIFT ||
                      state_q == serial_bus_pkg::WR_SHIFT) && last) begin
            last_seen <= 1'b1;
        end
    end

    always_comb begin
        state_d   = state_q;
        hdr_shift = 1'b0;
        cnt_clear = 1'b0;
        cnt_step  = 1'b0;
        cnt_mode  = 1'b1;
        addr_load = 1'b0;
        addr_step = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        rd_load   = 1'b0;
        rd_shift  = 1'b0;
        wr_shift  = 1'b0;
        case (state_q)
            serial_bus_pkg::IDLE: begin
                cnt_mode = 1'b0;
                // first header bit is the start code MSB
                if (control) begin
                    hdr_shift = 1'b1;
                    cnt_step  = 1'b1;
                    state_d   = serial_bus_pkg::HEADER;
                end
            end
            serial_bus_pkg::HEADER: begin
                cnt_mode  = 1'b0;
                hdr_shift = 1'b1;
                cnt_step  = 1'b1;
                if (count_done) begin
                    state_d = serial_bus_pkg::DECODE;
                end
            end
            serial_bus_pkg::DECODE: begin
                cnt_clear = 1'b1;
                if (!hdr_match) begin
                    state_d = serial_bus_pkg::IDLE;
                end else if (hdr.write) begin
                    addr_load = 1'b1;
                    state_d   = serial_bus_pkg::WR_SHIFT;
                end else begin
                    // read straight from the header address
                    addr_load = 1'b1;
                    mem_read  = 1'b1;
                    state_d   = serial_bus_pkg::RD_FETCH;
                end
            end
            serial_bus_pkg::RD_FETCH: begin
                cnt_clear = 1'b1;
                rd_load   = 1'b1;
                state_d   = serial_bus_pkg::RD_SHIFT;
            end
            serial_bus_pkg::RD_SHIFT: begin
                rd_shift = 1'b1;
                cnt_step = 1'b1;
                if (count_done) begin
                    cnt_clear = 1'b1;
                    if (rd_final) begin
                        state_d = serial_bus_pkg::IDLE;
                    end else begin
                        // prefetch next word for the fetch cycle
                        addr_step = 1'b1;
                        mem_read  = 1'b1;
                        state_d   = serial_bus_pkg::RD_FETCH;
                    end
                end
            end
            serial_bus_pkg::WR_SHIFT: begin
                wr_shift = valid;
                cnt_step = valid;
                if (count_done) begin
                    state_d = serial_bus_pkg::WR_COMMIT;
                end
            end
            serial_bus_pkg::WR_COMMIT: begin
                mem_write = 1'b1;
                cnt_clear = 1'b1;
                if (wr_final) begin
                    state_d = serial_bus_pkg::IDLE;
                end else begin
                    addr_step = 1'b1;
                    state_d   = serial_bus_pkg::WR_SHIFT;
                end
            end
            default: begin
                state_d = serial_bus_pkg::IDLE;
            end
        endcase
    end

endmodule

// File: hdl/serial_bus_slave.sv
`timescale 1ns/100ps

module serial_bus_slave #(
    parameter serial_bus_pkg::slave_id_t SLAVE_ID   = 1,
    parameter int                        ADDR_DEPTH = 2000
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);

    serial_bus_pkg::frame_hdr_t hdr;
    serial_bus_pkg::data_word_t rd_word;
    serial_bus_pkg::data_word_t wr_word;

    logic hdr_match;
    logic hdr_shift;
    logic count_done;
    logic cnt_clear;
    logic cnt_step;
    logic cnt_mode;
    logic addr_load;
    logic addr_step;
    logic mem_read;
    logic mem_write;
    logic rd_load;
    logic rd_shift;
    logic wr_shift;

    slave_frame_fsm i_fsm (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .valid      (valid),
        .last       (last),
        .count_done (count_done),
        .hdr_match  (hdr_match),
        .hdr        (hdr),
        .ready      (ready),
        .hdr_shift  (hdr_shift),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .cnt_mode   (cnt_mode),
        .addr_load  (addr_load),
        .addr_step  (addr_step),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .rd_load    (rd_load),
        .rd_shift   (rd_shift),
        .wr_shift   (wr_shift)
    );

    slave_bit_counter i_counter (
        .clk        (clk),
        .rstN       (rstN),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .cnt_mode   (cnt_mode),
        .count_done (count_done)
    );

    header_deserializer #(
        .SLAVE_ID (SLAVE_ID)
    ) i_header (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .hdr_shift (hdr_shift),
        .hdr       (hdr),
        .hdr_match (hdr_match)
    );

    data_shifter i_shifter (
        .clk      (clk),
        .rstN     (rstN),
        .wD       (wD),
        .wr_shift (wr_shift),
        .rd_load  (rd_load),
        .rd_shift (rd_shift),
        .rd_word  (rd_word),
        .wr_word  (wr_word),
        .rD       (rD)
    );

    slave_memory #(
        .ADDR_DEPTH (ADDR_DEPTH)
    ) i_memory (
        .clk       (clk),
        .rstN      (rstN),
        .addr_load (addr_load),
        .hdr_addr  (hdr.addr),
        .addr_step (addr_step),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .wr_word   (wr_word),
        .rd_word   (rd_word)
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rstN
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release a little after an edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rstN = 1'b1;
    end

endmodule

// File: bench/slave_checker.sv
`timescale 1ns/100ps

module slave_checker #(
    parameter serial_bus_pkg::slave_id_t SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    input  logic rD,
    input  logic ready,
    output int   error_count,
    output int   reads_checked
);

    localparam int W     = serial_bus_pkg::DATA_WIDTH;
    localparam int HLEN  = serial_bus_pkg::HDR_LEN;
    localparam int WORDS = 2 ** serial_bus_pkg::ADDR_WIDTH;

    typedef enum {ACT_IGNORE, ACT_WRITE, ACT_READ} frame_action_t;
    typedef enum {C_IDLE, C_HEADER, C_SKIP, C_DATA} watch_state_t;

    serial_bus_pkg::data_word_t shadow [WORDS];
    bit                         written [WORDS];

    watch_state_t               state;
    frame_action_t              action;
    serial_bus_pkg::frame_hdr_t frame;
    logic [HLEN-1:0]            hdr_bits;
    serial_bus_pkg::mem_addr_t  addr;
    serial_bus_pkg::data_word_t word;
    int                         hdr_count;
    int                         bit_idx;
    int                         gap;
    int                         gap_expect;
    bit                         gap_done;
    bit                         last_seen;
    bit                         check_idle;

    // header meaning taken from the bus rules
    function automatic serial_bus_pkg::frame_hdr_t decode_frame(
        input  logic [HLEN-1:0] bits,
        output frame_action_t   act
    );
        serial_bus_pkg::frame_hdr_t h;
        h = serial_bus_pkg::frame_hdr_t'(bits);
        if (!(&h.start) || h.id != SLAVE_ID) begin
            act = ACT_IGNORE;
        end else if (h.write) begin
            act = ACT_WRITE;
        end else begin
            act = ACT_READ;
        end
        return h;
    endfunction

    // msb leaves first
    function automatic logic expected_bit(input serial_bus_pkg::mem_addr_t a, input int idx);
        return shadow[a][W - 1 - idx];
    endfunction

    task automatic note_failure(input string msg);
        $display("%s at %0t", msg, $time);
        error_count++;
    endtask

    task automatic start_word();
        bit_idx   = 0;
        gap       = 0;
        gap_done  = 1'b0;
        last_seen = 1'b0;
        word      = '0;
    endtask

    initial begin
        error_count   = 0;
        reads_checked = 0;
        state         = C_IDLE;
        check_idle    = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            written[i] = 1'b0;
        end
    end

    // mid-cycle sampling, inputs change just after the rising edge
    always @(negedge clk) begin
        if (!rstN) begin
            state      = C_IDLE;
            check_idle = 1'b0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (check_idle && !ready) begin
                        note_failure("slave stayed busy after an ignored header");
                    end
                    check_idle = 1'b0;
                    if (ready && control) begin
                        hdr_bits  = '0;
                        hdr_bits[0] = 1'b1;
                        hdr_count = 1;
                        state     = C_HEADER;
                    end
                end
                C_HEADER: begin
                    hdr_bits  = {hdr_bits[HLEN-2:0], control};
                    hdr_count = hdr_count + 1;
                    if (hdr_count == HLEN) begin
                        frame = decode_frame(hdr_bits, action);
                        addr  = frame.addr;
                        // a read also waits for the fetch before its first word
                        gap_expect = (action == ACT_READ) ? 2 : 1;
                        start_word();
                        if (action == ACT_IGNORE) begin
                            state = C_SKIP;
                        end else begin
                            state = C_DATA;
                        end
                    end
                end
                C_SKIP: begin
                    if (ready) begin
                        note_failure("slave showed no decode cycle after an ignored header");
                    end
                    check_idle = 1'b1;
                    state      = C_IDLE;
                end
                C_DATA: begin
                    if (!ready) begin
                        if (gap_done) begin
                            note_failure("ready dropped in the middle of a data word");
                        end
                        gap = gap + 1;
                    end else begin
                        if (!gap_done) begin
                            gap_done = 1'b1;
                            if (gap != gap_expect) begin
                                $display("ready was low %0d cycles before word at %0d, not %0d",
                                         gap, addr, gap_expect);
                                error_count++;
                            end
                            if (action == ACT_READ && !written[addr]) begin
                                note_failure($sformatf("read of unwritten address %0d", addr));
                            end
                        end
                        if (last) begin
                            last_seen = 1'b1;
                        end
                        if (action == ACT_READ) begin
                            if (written[addr] && rD !== expected_bit(addr, bit_idx)) begin
                                $display("Error at %0t: address %0d bit %0d read %b, expected %b",
                                         $time, addr, W - 1 - bit_idx, rD,
                                         expected_bit(addr, bit_idx));
                                error_count++;
                            end
                            bit_idx++;
                        end else if (valid) begin
                            word = {word[W-2:0], wD};
                            bit_idx++;
                        end
                        if (bit_idx == W) begin
                            if (action == ACT_WRITE) begin
                                shadow[addr]  = word;
                                written[addr] = 1'b1;
                            end else if (written[addr]) begin
                                reads_checked++;
                            end
                            if (!frame.burst || last_seen) begin
                                state = C_IDLE;
                            end else begin
                                addr       = addr + 1'b1;
                                gap_expect = 1;
                                start_word();
                            end
                        end
                    end
                end
                default: begin
                    state = C_IDLE;
                end
            endcase
        end
    end

endmodule

// File: bench/serial_bus_slave_tb.sv
`timescale 1ns/100ps

module serial_bus_slave_tb;

    localparam serial_bus_pkg::slave_id_t SLAVE_ID = 1;
    localparam int ADDR_DEPTH     = 2000;
    localparam int W              = serial_bus_pkg::DATA_WIDTH;
    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int RANDOM_SEED    = 83;
    localparam int MAX_BURST      = 8;
    localparam int RANDOM_XFERS   = 40;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    int checker_errors;
    int reads_checked;
    int local_errors;
    int pass_count;
    int fail_count;
    int test_num;
    int errors_before;
    int reads_before;
    bit timed_out;

    serial_bus_pkg::data_word_t burst_data [MAX_BURST];
    // write ranges of the random sequence so reads hit written words
    int rec_addr [RANDOM_XFERS];
    int rec_len [RANDOM_XFERS];
    int rec_count;

    tb_clock_gen i_clock (
        .clk  (clk),
        .rstN (rstN)
    );

    serial_bus_slave #(
        .SLAVE_ID   (SLAVE_ID),
        .ADDR_DEPTH (ADDR_DEPTH)
    ) i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .ready   (ready)
    );

    slave_checker #(
        .SLAVE_ID (SLAVE_ID)
    ) i_checker (
        .clk           (clk),
        .rstN          (rstN),
        .control       (control),
        .wD            (wD),
        .valid         (valid),
        .last          (last),
        .rD            (rD),
        .ready         (ready),
        .error_count   (checker_errors),
        .reads_checked (reads_checked)
    );

    function automatic serial_bus_pkg::frame_hdr_t make_header(
        input logic [serial_bus_pkg::START_WIDTH-1:0] start,
        input serial_bus_pkg::slave_id_t              id,
        input logic                                   write,
        input logic                                   burst,
        input int                                     addr
    );
        serial_bus_pkg::frame_hdr_t h;
        h.start = start;
        h.id    = id;
        h.write = write;
        h.burst = burst;
        h.addr  = serial_bus_pkg::mem_addr_t'(addr);
        return h;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
        timed_out = 1'b1;
        local_errors++;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready && !timed_out) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
            if (!ready && cycles >= TIMEOUT_CYCLES) begin
                report_timeout("ready did not rise");
            end
        end
    endtask

    task automatic send_header(input serial_bus_pkg::frame_hdr_t h);
        int i;
        for (i = serial_bus_pkg::HDR_LEN - 1; i >= 0; i--) begin
            control = h[i];
            @(posedge clk);
            #DRIVE_DELAY;
        end
        control = 1'b0;
    endtask

    task automatic write_words(input int addr, input int n, input bit burst, input bit stall);
        int w;
        int k;
        int cycles;
        bit accepted;
        wait_ready();
        if (timed_out) return;
        send_header(make_header('1, SLAVE_ID, 1'b1, burst, addr));
        for (w = 0; w < n; w++) begin
            for (k = W - 1; k >= 0; k--) begin
                accepted = 1'b0;
                cycles   = 0;
                while (!accepted && !timed_out) begin
                    wD    = burst_data[w][k];
                    valid = stall ? (($urandom % 4) != 0) : 1'b1;
                    last  = burst && (w == n - 1);
                    // taken at the coming edge
                    accepted = ready && valid;
                    @(posedge clk);
                    #DRIVE_DELAY;
                    cycles++;
                    if (!accepted && cycles >= TIMEOUT_CYCLES) begin
                        report_timeout("write bit was not accepted");
                    end
                end
            end
        end
        wD    = 1'b0;
        valid = 1'b0;
        last  = 1'b0;
    endtask

    task automatic read_words(input int addr, input int n, input bit burst);
        int w;
        int k;
        wait_ready();
        if (timed_out) return;
        send_header(make_header('1, SLAVE_ID, 1'b0, burst, addr));
        for (w = 0; w < n && !timed_out; w++) begin
            // one bit per cycle with no back-pressure once ready rises
            wait_ready();
            last = burst && (w == n - 1);
            for (k = 0; k < W; k++) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            last = 1'b0;
        end
    endtask

    task automatic send_ignored_header(input logic [2:0] start, input int id, input int addr);
        serial_bus_pkg::data_word_t junk;
        int k;
        wait_ready();
        if (timed_out) return;
        send_header(make_header(start, serial_bus_pkg::slave_id_t'(id), 1'b1, 1'b0, addr));
        wait_ready();
        // a word that a slave taking the header would store
        junk = $urandom;
        for (k = W - 1; k >= 0; k--) begin
            wD    = junk[k];
            valid = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        wD    = 1'b0;
        valid = 1'b0;
        wait_ready();
    endtask

    task automatic fill_random_words(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            burst_data[i] = $urandom;
        end
    endtask

    task automatic begin_test();
        test_num++;
        errors_before = local_errors + checker_errors;
        reads_before  = reads_checked;
    endtask

    task automatic end_test(input string name);
        int errs;
        if (reads_checked == reads_before) begin
            $display("no read data was compared in test %0d", test_num);
            local_errors++;
        end
        errs = local_errors + checker_errors - errors_before;
        if (errs == 0) begin
            pass_count++;
            $display("test %0d %s: PASS", test_num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: FAIL with %0d errors", test_num, name, errs);
        end
    endtask

    initial begin
        int seed;
        int cycles;
        int addr;
        int kept_addr;
        int n;
        int t;
        int idx;
        bit burst;
        control      = 1'b0;
        wD           = 1'b0;
        valid        = 1'b0;
        last         = 1'b0;
        local_errors = 0;
        pass_count   = 0;
        fail_count   = 0;
        test_num     = 0;
        rec_count    = 0;
        timed_out    = 1'b0;
        seed         = RANDOM_SEED;
        seed         = $urandom(seed);

        cycles = 0;
        while (rstN !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            report_timeout("reset was not released");
        end
        #DRIVE_DELAY;

        begin_test();
        if (ready !== 1'b1) begin
            $display("Error at %0t: ready is %b after reset", $time, ready);
            local_errors++;
        end
        kept_addr    = $urandom % ADDR_DEPTH;
        burst_data[0] = $urandom;
        write_words(kept_addr, 1, 1'b0, 1'b0);
        read_words(kept_addr, 1, 1'b0);
        end_test("reset and single transfer");

        begin_test();
        n    = 4 + $urandom % 5;
        addr = $urandom % (ADDR_DEPTH - n + 1);
        fill_random_words(n);
        write_words(addr, n, 1'b1, 1'b0);
        read_words(addr, n, 1'b1);
        end_test("burst transfer");

        // same word twice with gaps in valid on the second copy
        begin_test();
        addr = $urandom % (ADDR_DEPTH - 1);
        burst_data[0] = $urandom;
        write_words(addr, 1, 1'b0, 1'b0);
        write_words(addr + 1, 1, 1'b0, 1'b1);
        read_words(addr, 2, 1'b1);
        end_test("stalled write");

        begin_test();
        send_ignored_header(3'b111, 2, kept_addr);
        read_words(kept_addr, 1, 1'b0);
        end_test("wrong slave id");

        begin_test();
        send_ignored_header(3'b110, SLAVE_ID, kept_addr);
        read_words(kept_addr, 1, 1'b0);
        end_test("bad start code");

        begin_test();
        for (t = 0; t < RANDOM_XFERS; t++) begin
            if (($urandom % 2) != 0) begin
                n = 1;
            end else begin
                n = 2 + $urandom % (MAX_BURST - 1);
            end
            if (rec_count == 0 || ($urandom % 2) != 0) begin
                addr = $urandom % (ADDR_DEPTH - n + 1);
                fill_random_words(n);
                write_words(addr, n, n > 1, ($urandom % 2) != 0);
                rec_addr[rec_count] = addr;
                rec_len[rec_count]  = n;
                rec_count++;
            end else begin
                idx  = $urandom % rec_count;
                addr = rec_addr[idx];
                if (n > rec_len[idx]) begin
                    n = rec_len[idx];
                end
                burst = n > 1;
                read_words(addr, n, burst);
            end
        end
        end_test("random sequence");

        $display("%0d tests passed, %0d failed, %0d errors", pass_count, fail_count,
                 local_errors + checker_errors);
        if (fail_count == 0 && local_errors + checker_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: serial_bus_slave.f
hdl/serial_bus_pkg.sv
hdl/slave_bit_counter.sv
hdl/header_deserializer.sv
hdl/data_shifter.sv
hdl/slave_memory.sv
hdl/slave_frame_fsm.sv
hdl/serial_bus_slave.sv
bench/tb_clock_gen.sv
bench/slave_checker.sv
bench/serial_bus_slave_tb.sv
